// File: fir_cfg_pkg.sv
package fir_cfg_pkg;

  // Word types
  // Samples, coefficients, outputs and register values
  typedef logic [31:0] data_t;
  // Byte address on the AXI4-Lite port
  typedef logic [11:0] lite_addr_t;
  // Word address into the tap RAM or the data RAM
  typedef logic [9:0]  ram_addr_t;

  // Register map
  localparam lite_addr_t REG_AP_CTRL  = 12'h000;
  localparam lite_addr_t REG_DATA_LEN = 12'h010;
  localparam lite_addr_t REG_TAP_NUM  = 12'h014;
  // Tap k lives at REG_TAP_BASE + 4k
  localparam lite_addr_t REG_TAP_BASE = 12'h080;

  // Bit positions inside REG_AP_CTRL
  localparam int AP_START = 0;
  localparam int AP_DONE  = 1;
  localparam int AP_IDLE  = 2;

  // Core sequencer states
  typedef enum logic [2:0] {
    IDLE,
    CLEAR,
    WAIT_SAMPLE,
    WRITE_SAMPLE,
    MAC,
    DRAIN,
    OUTPUT
  } core_state_e;

endpackage

// File: fir_bus_pkg.sv
package fir_bus_pkg;

  // Tap RAM port
  // Byte write enables, all four set together for a tap write
  typedef struct packed {
    logic                   en;
    logic [3:0]             we;
    fir_cfg_pkg::ram_addr_t addr;
    fir_cfg_pkg::data_t     di;
  } tap_port_t;

  // Data RAM port
  // Single write enable, whole words only
  typedef struct packed {
    logic                   en;
    logic                   we;
    fir_cfg_pkg::ram_addr_t addr;
    fir_cfg_pkg::data_t     di;
  } data_port_t;

  // One captured input sample
  // Travels from the stream holding register to the arbiter
  typedef struct packed {
    logic               valid;
    fir_cfg_pkg::data_t data;
  } sample_beat_t;

endpackage

// File: axi4_lite_slave.sv
`timescale 1ns/1ps

module axi4_lite_slave #(
  parameter int TAP_NUM_WIDTH  = 10,
  parameter int DATA_NUM_WIDTH = 10
) (
  input  logic                        aclk,
  input  logic                        rst_n,
  input  fir_cfg_pkg::lite_addr_t     s_awaddr,
  input  logic                        s_awvalid,
  output logic                        s_awready,
  input  fir_cfg_pkg::data_t          s_wdata,
  input  logic                        s_wvalid,
  output logic                        s_wready,
  input  fir_cfg_pkg::lite_addr_t     s_araddr,
  input  logic                        s_arvalid,
  output logic                        s_arready,
  output fir_cfg_pkg::data_t          s_rdata,
  output logic                        s_rvalid,
  input  logic                        s_rready,
  input  logic                        tap_grant,
  output fir_bus_pkg::tap_port_t      tap_req,
  input  fir_cfg_pkg::data_t          tap_do,
  input  logic                        ap_done,
  output logic                        ap_start,
  output logic                        ap_idle,
  output logic [DATA_NUM_WIDTH-1:0]   data_len,
  output logic [TAP_NUM_WIDTH-1:0]    tap_num
);

  logic                    aw_is_tap;
  logic                    ar_is_tap;
  logic                    wr_go;
  logic                    wr_tap;
  logic                    ar_go;
  logic                    tap_rd_q;
  logic                    ap_done_q;
  fir_cfg_pkg::lite_addr_t aw_off;
  fir_cfg_pkg::lite_addr_t ar_off;
  fir_cfg_pkg::data_t      reg_rdata;

  // Anything at or above the tap base is a coefficient
  assign aw_is_tap = s_awaddr >= fir_cfg_pkg::REG_TAP_BASE;
  assign ar_is_tap = s_araddr >= fir_cfg_pkg::REG_TAP_BASE;
  assign aw_off    = s_awaddr - fir_cfg_pkg::REG_TAP_BASE;
  assign ar_off    = s_araddr - fir_cfg_pkg::REG_TAP_BASE;

  // Address and data accepted together
  // Tap writes also need the RAM grant
  assign wr_go     = s_awvalid && s_wvalid && (!aw_is_tap || tap_grant);
  assign wr_tap    = wr_go && aw_is_tap;
  assign s_awready = wr_go;
  assign s_wready  = wr_go;

  // One read in flight at a time
  // Tap read yields the RAM port to a same-cycle tap write
  assign s_arready = s_arvalid && !s_rvalid && !tap_rd_q &&
                     (!ar_is_tap || (tap_grant && !wr_tap));
  assign ar_go     = s_arvalid && s_arready;

  // Tap RAM request, write first
  always_comb begin
    tap_req = '0;
    if (wr_tap) begin
      tap_req.en   = 1'b1;
      tap_req.we   = 4'hf;
      tap_req.addr = fir_cfg_pkg::ram_addr_t'(aw_off >> 2);
      tap_req.di   = s_wdata;
    end else if (ar_go && ar_is_tap) begin
      tap_req.en   = 1'b1;
      tap_req.addr = fir_cfg_pkg::ram_addr_t'(ar_off >> 2);
    end
  end

  // Register read mux
  always_comb begin
    reg_rdata = '0;
    case (s_araddr)
      fir_cfg_pkg::REG_AP_CTRL: begin
        reg_rdata[fir_cfg_pkg::AP_START] = ap_start;
        reg_rdata[fir_cfg_pkg::AP_DONE]  = ap_done_q;
        reg_rdata[fir_cfg_pkg::AP_IDLE]  = ap_idle;
      end
      fir_cfg_pkg::REG_DATA_LEN: reg_rdata[DATA_NUM_WIDTH-1:0] = data_len;
      fir_cfg_pkg::REG_TAP_NUM:  reg_rdata[TAP_NUM_WIDTH-1:0]  = tap_num;
      default:                   reg_rdata = '0;
    endcase
  end

  // Control and configuration registers
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      ap_start  <= 1'b0;
      ap_done_q <= 1'b0;
      ap_idle   <= 1'b1;
      data_len  <= '0;
      tap_num   <= '0;
    end else begin
      // Start lasts one cycle, the core is busy from then on
      if (ap_start) begin
        ap_start <= 1'b0;
        ap_idle  <= 1'b0;
      end
      // End of run from the core
      if (ap_done) begin
        ap_done_q <= 1'b1;
        ap_idle   <= 1'b1;
      end
      if (wr_go && !aw_is_tap) begin
        case (s_awaddr)
          fir_cfg_pkg::REG_AP_CTRL: begin
            // Only honoured while idle, done drops with the new start
            if (s_wdata[fir_cfg_pkg::AP_START] && ap_idle && !ap_start) begin
              ap_start  <= 1'b1;
              ap_done_q <= 1'b0;
            end
          end
          fir_cfg_pkg::REG_DATA_LEN: data_len <= s_wdata[DATA_NUM_WIDTH-1:0];
          fir_cfg_pkg::REG_TAP_NUM:  tap_num  <= s_wdata[TAP_NUM_WIDTH-1:0];
          default: ;
        endcase
      end
    end
  end

  // Read response control
  // Registers answer next cycle, taps one later for the RAM
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      tap_rd_q <= 1'b0;
      s_rvalid <= 1'b0;
    end else begin
      tap_rd_q <= ar_go && ar_is_tap;
      if ((ar_go && !ar_is_tap) || tap_rd_q) begin
        s_rvalid <= 1'b1;
      end else if (s_rready) begin
        s_rvalid <= 1'b0;
      end
    end
  end

  // Read data, held while rvalid waits
  always_ff @(posedge aclk) begin
    if (ar_go && !ar_is_tap) begin
      s_rdata <= reg_rdata;
    end else if (tap_rd_q) begin
      s_rdata <= tap_do;
    end
  end

endmodule

// File: axi4_stream_slave_bram.sv
`timescale 1ns/1ps

module axi4_stream_slave_bram (
  input  logic                      aclk,
  input  logic                      rst_n,
  input  logic                      ss_tvalid,
  input  fir_cfg_pkg::data_t        ss_tdata,
  output logic                      ss_tready,
  output fir_bus_pkg::sample_beat_t sample,
  input  logic                      sample_take
);

  logic               hold_valid;
  fir_cfg_pkg::data_t hold_data;

  // Accept only into an empty slot
  assign ss_tready = !hold_valid;

  // Occupancy
  // Fill and take never meet, take needs a full slot
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      hold_valid <= 1'b0;
    end else if (ss_tvalid && ss_tready) begin
      hold_valid <= 1'b1;
    end else if (sample_take) begin
      hold_valid <= 1'b0;
    end
  end

  // Sample payload
  always_ff @(posedge aclk) begin
    if (ss_tvalid && ss_tready) begin
      hold_data <= ss_tdata;
    end
  end

  // Offered to the arbiter until taken
  assign sample.valid = hold_valid;
  assign sample.data  = hold_data;

endmodule

// File: bram_access_arbiter.sv
`timescale 1ns/1ps

module bram_access_arbiter (
  input  logic                      ap_idle,
  input  fir_bus_pkg::tap_port_t    lite_tap,
  output logic                      tap_grant,
  input  fir_bus_pkg::sample_beat_t sample,
  output logic                      sample_take,
  input  logic                      core_wait,
  input  fir_bus_pkg::tap_port_t    core_tap,
  input  fir_bus_pkg::data_port_t   core_data,
  output fir_bus_pkg::tap_port_t    tap_ram,
  output fir_bus_pkg::data_port_t   data_ram
);

  // Lite side owns the tap RAM only between runs
  assign tap_grant = ap_idle;

  // Take the held sample while the core waits for one
  assign sample_take = core_wait && sample.valid;

  // Tap RAM steering
  always_comb begin
    if (ap_idle) begin
      tap_ram = lite_tap;
    end else begin
      tap_ram = core_tap;
    end
  end

  // Data RAM steering
  // The core supplies the write pointer in its wait state
  // The sample word itself comes from the holding register
  always_comb begin
    data_ram = core_data;
    if (sample_take) begin
      data_ram.en = 1'b1;
      data_ram.we = 1'b1;
      data_ram.di = sample.data;
    end
  end

endmodule

// File: fir_core.sv
`timescale 1ns/1ps

module fir_core #(
  parameter int TAP_NUM_WIDTH  = 10,
  parameter int DATA_NUM_WIDTH = 10
) (
  input  logic                      aclk,
  input  logic                      rst_n,
  input  logic                      ap_start,
  output logic                      ap_done,
  input  logic [TAP_NUM_WIDTH-1:0]  tap_num,
  input  logic [DATA_NUM_WIDTH-1:0] data_len,
  input  fir_cfg_pkg::data_t        tap_do,
  input  fir_cfg_pkg::data_t        data_do,
  input  logic                      sample_take,
  output logic                      core_wait,
  output fir_bus_pkg::tap_port_t    core_tap,
  output fir_bus_pkg::data_port_t   core_data,
  input  logic                      sm_tready,
  output logic                      sm_tvalid,
  output fir_cfg_pkg::data_t        sm_tdata,
  output logic                      sm_tlast
);

  fir_cfg_pkg::core_state_e  state;
  fir_cfg_pkg::ram_addr_t    clr_cnt;
  logic [TAP_NUM_WIDTH-1:0]  wptr;
  logic [TAP_NUM_WIDTH-1:0]  ridx;
  logic [TAP_NUM_WIDTH-1:0]  tap_k;
  logic [TAP_NUM_WIDTH-1:0]  tap_last;
  logic [DATA_NUM_WIDTH-1:0] out_cnt;
  logic                      out_last;
  logic                      mac_vld;
  fir_cfg_pkg::data_t        acc;

  assign tap_last = tap_num - 1'b1;
  // Final output of the run
  assign out_last = out_cnt == data_len - 1'b1;

  // Sequencer
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= fir_cfg_pkg::IDLE;
      clr_cnt <= '0;
      wptr    <= '0;
      ridx    <= '0;
      tap_k   <= '0;
      out_cnt <= '0;
      mac_vld <= 1'b0;
      ap_done <= 1'b0;
    end else begin
      ap_done <= 1'b0;
      // RAM words for an issued MAC arrive one cycle later
      mac_vld <= state == fir_cfg_pkg::MAC;
      case (state)
        fir_cfg_pkg::IDLE: begin
          if (ap_start) begin
            state   <= fir_cfg_pkg::CLEAR;
            clr_cnt <= '0;
            wptr    <= '0;
            out_cnt <= '0;
          end
        end
        fir_cfg_pkg::CLEAR: begin
          // Sweep every data RAM word to zero
          clr_cnt <= clr_cnt + 1'b1;
          if (clr_cnt == '1) begin
            state <= fir_cfg_pkg::WAIT_SAMPLE;
          end
        end
        fir_cfg_pkg::WAIT_SAMPLE: begin
          if (sample_take) begin
            state <= fir_cfg_pkg::WRITE_SAMPLE;
          end
        end
        fir_cfg_pkg::WRITE_SAMPLE: begin
          // Newest sample sits at wptr, walk backwards from there
          ridx  <= wptr;
          tap_k <= '0;
          wptr  <= (wptr == tap_last) ? '0 : wptr + 1'b1;
          state <= fir_cfg_pkg::MAC;
        end
        fir_cfg_pkg::MAC: begin
          tap_k <= tap_k + 1'b1;
          ridx  <= (ridx == '0) ? tap_last : ridx - 1'b1;
          if (tap_k == tap_last) begin
            state <= fir_cfg_pkg::DRAIN;
          end
        end
        // Last product lands in acc here
        fir_cfg_pkg::DRAIN: state <= fir_cfg_pkg::OUTPUT;
        fir_cfg_pkg::OUTPUT: begin
          if (sm_tready) begin
            out_cnt <= out_cnt + 1'b1;
            if (out_last) begin
              state   <= fir_cfg_pkg::IDLE;
              ap_done <= 1'b1;
            end else begin
              state <= fir_cfg_pkg::WAIT_SAMPLE;
            end
          end
        end
        default: state <= fir_cfg_pkg::IDLE;
      endcase
    end
  end

  // Accumulator, low 32 bits of the two's-complement sum
  always_ff @(posedge aclk) begin
    if (state == fir_cfg_pkg::WRITE_SAMPLE) begin
      acc <= '0;
    end else if (mac_vld) begin
      acc <= acc + tap_do * data_do;
    end
  end

  // RAM requests
  always_comb begin
    core_tap  = '0;
    core_data = '0;
    case (state)
      fir_cfg_pkg::CLEAR: begin
        core_data.en   = 1'b1;
        core_data.we   = 1'b1;
        core_data.addr = clr_cnt;
      end
      // Address only, the arbiter fills in the write
      fir_cfg_pkg::WAIT_SAMPLE: core_data.addr = fir_cfg_pkg::ram_addr_t'(wptr);
      fir_cfg_pkg::MAC: begin
        core_tap.en    = 1'b1;
        core_tap.addr  = fir_cfg_pkg::ram_addr_t'(tap_k);
        core_data.en   = 1'b1;
        core_data.addr = fir_cfg_pkg::ram_addr_t'(ridx);
      end
      default: ;
    endcase
  end

  assign core_wait = state == fir_cfg_pkg::WAIT_SAMPLE;

  // Output beat, held until accepted
  assign sm_tvalid = state == fir_cfg_pkg::OUTPUT;
  assign sm_tdata  = acc;
  assign sm_tlast  = out_last;

endmodule

// File: fir_top.sv
`timescale 1ns/1ps

module fir_top #(
  parameter int TAP_NUM_WIDTH  = 10,
  parameter int DATA_NUM_WIDTH = 10
) (
  input  logic                    aclk,
  input  logic                    rst_n,
  // AXI4-Lite
  input  fir_cfg_pkg::lite_addr_t s_awaddr,
  input  logic                    s_awvalid,
  output logic                    s_awready,
  input  fir_cfg_pkg::data_t      s_wdata,
  input  logic                    s_wvalid,
  output logic                    s_wready,
  input  fir_cfg_pkg::lite_addr_t s_araddr,
  input  logic                    s_arvalid,
  output logic                    s_arready,
  output fir_cfg_pkg::data_t      s_rdata,
  output logic                    s_rvalid,
  input  logic                    s_rready,
  // Input stream, length comes from REG_DATA_LEN so tlast is ignored
  input  logic                    ss_tvalid,
  input  fir_cfg_pkg::data_t      ss_tdata,
  input  logic                    ss_tlast,
  output logic                    ss_tready,
  // Output stream
  input  logic                    sm_tready,
  output logic                    sm_tvalid,
  output fir_cfg_pkg::data_t      sm_tdata,
  output logic                    sm_tlast,
  // External RAMs
  input  fir_cfg_pkg::data_t      tap_do,
  output fir_bus_pkg::tap_port_t  tap_ram,
  input  fir_cfg_pkg::data_t      data_do,
  output fir_bus_pkg::data_port_t data_ram
);

  fir_bus_pkg::tap_port_t    lite_tap;
  fir_bus_pkg::tap_port_t    core_tap;
  fir_bus_pkg::data_port_t   core_data;
  fir_bus_pkg::sample_beat_t sample;
  logic                      tap_grant;
  logic                      sample_take;
  logic                      core_wait;
  logic                      ap_start;
  logic                      ap_done;
  logic                      ap_idle;
  logic [DATA_NUM_WIDTH-1:0] data_len;
  logic [TAP_NUM_WIDTH-1:0]  tap_num;

  // Configuration and tap access
  axi4_lite_slave #(
    .TAP_NUM_WIDTH  (TAP_NUM_WIDTH),
    .DATA_NUM_WIDTH (DATA_NUM_WIDTH)
  ) u_axi4_lite_slave (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .s_awaddr  (s_awaddr),
    .s_awvalid (s_awvalid),
    .s_awready (s_awready),
    .s_wdata   (s_wdata),
    .s_wvalid  (s_wvalid),
    .s_wready  (s_wready),
    .s_araddr  (s_araddr),
    .s_arvalid (s_arvalid),
    .s_arready (s_arready),
    .s_rdata   (s_rdata),
    .s_rvalid  (s_rvalid),
    .s_rready  (s_rready),
    .tap_grant (tap_grant),
    .tap_req   (lite_tap),
    .tap_do    (tap_do),
    .ap_done   (ap_done),
    .ap_start  (ap_start),
    .ap_idle   (ap_idle),
    .data_len  (data_len),
    .tap_num   (tap_num)
  );

  // Input sample holding register
  axi4_stream_slave_bram u_axi4_stream_slave_bram (
    .aclk        (aclk),
    .rst_n       (rst_n),
    .ss_tvalid   (ss_tvalid),
    .ss_tdata    (ss_tdata),
    .ss_tready   (ss_tready),
    .sample      (sample),
    .sample_take (sample_take)
  );

  // RAM port steering
  bram_access_arbiter u_bram_access_arbiter (
    .ap_idle     (ap_idle),
    .lite_tap    (lite_tap),
    .tap_grant   (tap_grant),
    .sample      (sample),
    .sample_take (sample_take),
    .core_wait   (core_wait),
    .core_tap    (core_tap),
    .core_data   (core_data),
    .tap_ram     (tap_ram),
    .data_ram    (data_ram)
  );

  // Filter datapath
  fir_core #(
    .TAP_NUM_WIDTH  (TAP_NUM_WIDTH),
    .DATA_NUM_WIDTH (DATA_NUM_WIDTH)
  ) u_fir_core (
    .aclk        (aclk),
    .rst_n       (rst_n),
    .ap_start    (ap_start),
    .ap_done     (ap_done),
    .tap_num     (tap_num),
    .data_len    (data_len),
    .tap_do      (tap_do),
    .data_do     (data_do),
    .sample_take (sample_take),
    .core_wait   (core_wait),
    .core_tap    (core_tap),
    .core_data   (core_data),
    .sm_tready   (sm_tready),
    .sm_tvalid   (sm_tvalid),
    .sm_tdata    (sm_tdata),
    .sm_tlast    (sm_tlast)
  );

endmodule

// File: fir_top_properties.sv
`timescale 1ns/1ps

module fir_top_properties (
  input logic                    aclk,
  input logic                    rst_n,
  input logic                    ap_idle,
  input logic                    s_awready,
  input logic                    s_wready,
  input logic                    s_arready,
  input logic                    s_rvalid,
  input logic                    s_rready,
  input logic                    sm_tvalid,
  input logic                    sm_tready,
  input fir_cfg_pkg::data_t      sm_tdata,
  input fir_bus_pkg::tap_port_t  tap_ram,
  input fir_bus_pkg::data_port_t data_ram
);

  // Output beat frozen while the sink stalls
  a_sm_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata))
    else $error("sm_tvalid dropped or sm_tdata changed while stalled");

  // Read data waits for the master
  a_rvalid_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    s_rvalid && !s_rready |=> s_rvalid)
    else $error("s_rvalid dropped before s_rready");

  // Coefficients only change between runs
  a_tap_write_idle: assert property (@(posedge aclk) disable iff (!rst_n)
    !ap_idle |-> !(tap_ram.en && (tap_ram.we != 4'h0)))
    else $error("tap RAM written while the core is busy");

  a_reset_quiet: assert property (@(posedge aclk)
    !rst_n |-> !(s_awready || s_wready || s_arready || s_rvalid || sm_tvalid ||
                 tap_ram.en || data_ram.en))
    else $error("control output active during reset");

endmodule

bind fir_top fir_top_properties u_fir_top_properties (
  .aclk      (aclk),
  .rst_n     (rst_n),
  .ap_idle   (ap_idle),
  .s_awready (s_awready),
  .s_wready  (s_wready),
  .s_arready (s_arready),
  .s_rvalid  (s_rvalid),
  .s_rready  (s_rready),
  .sm_tvalid (sm_tvalid),
  .sm_tready (sm_tready),
  .sm_tdata  (sm_tdata),
  .tap_ram   (tap_ram),
  .data_ram  (data_ram)
);

// File: tb_fir_top.sv
`timescale 1ns/1ps

module tb_fir_top;

  localparam int TAP_NUM_WIDTH  = 10;
  localparam int DATA_NUM_WIDTH = 10;
  localparam int MAX_TAPS       = 8;
  localparam int MAX_SAMPLES    = 16;
  // Three runs of 1024 clear cycles plus about 40 cycles per sample,
  // then register traffic, with generous margin
  localparam int TIMEOUT_CYCLES = 20000;

  logic                      aclk;
  logic                      rst_n;
  fir_cfg_pkg::lite_addr_t   s_awaddr;
  logic                      s_awvalid;
  logic                      s_awready;
  fir_cfg_pkg::data_t        s_wdata;
  logic                      s_wvalid;
  logic                      s_wready;
  fir_cfg_pkg::lite_addr_t   s_araddr;
  logic                      s_arvalid;
  logic                      s_arready;
  fir_cfg_pkg::data_t        s_rdata;
  logic                      s_rvalid;
  logic                      s_rready;
  logic                      ss_tvalid;
  fir_cfg_pkg::data_t        ss_tdata;
  logic                      ss_tlast;
  logic                      ss_tready;
  logic                      sm_tready;
  logic                      sm_tvalid;
  fir_cfg_pkg::data_t        sm_tdata;
  logic                      sm_tlast;
  fir_cfg_pkg::data_t        tap_do = '0;
  fir_cfg_pkg::data_t        data_do = '0;
  fir_bus_pkg::tap_port_t    tap_ram;
  fir_bus_pkg::data_port_t   data_ram;

  // RAM contents and test vectors
  fir_cfg_pkg::data_t        tap_mem [0:1023];
  fir_cfg_pkg::data_t        data_mem [0:1023];
  fir_cfg_pkg::data_t        taps [0:MAX_TAPS-1];
  fir_cfg_pkg::data_t        xs [0:MAX_SAMPLES-1];
  logic [31:0]               lfsr_state;
  int                        cycle_count = 0;
  bit                        run_over;

  fir_top #(
    .TAP_NUM_WIDTH  (TAP_NUM_WIDTH),
    .DATA_NUM_WIDTH (DATA_NUM_WIDTH)
  ) uut (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .s_awaddr  (s_awaddr),
    .s_awvalid (s_awvalid),
    .s_awready (s_awready),
    .s_wdata   (s_wdata),
    .s_wvalid  (s_wvalid),
    .s_wready  (s_wready),
    .s_araddr  (s_araddr),
    .s_arvalid (s_arvalid),
    .s_arready (s_arready),
    .s_rdata   (s_rdata),
    .s_rvalid  (s_rvalid),
    .s_rready  (s_rready),
    .ss_tvalid (ss_tvalid),
    .ss_tdata  (ss_tdata),
    .ss_tlast  (ss_tlast),
    .ss_tready (ss_tready),
    .sm_tready (sm_tready),
    .sm_tvalid (sm_tvalid),
    .sm_tdata  (sm_tdata),
    .sm_tlast  (sm_tlast),
    .tap_do    (tap_do),
    .tap_ram   (tap_ram),
    .data_do   (data_do),
    .data_ram  (data_ram)
  );

  // 4 ns clock
  always #2 aclk = ~aclk;

  // Run length guard
  always @(posedge aclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: test still running after %0d cycles", cycle_count);
      stop_with_failure();
    end
  end

  // Tap RAM, one cycle read latency, read before write
  always @(posedge aclk) begin
    if (tap_ram.en) begin
      if (|tap_ram.we) begin
        tap_mem[tap_ram.addr] <= tap_ram.di;
      end
      tap_do <= tap_mem[tap_ram.addr];
    end
  end

  // Data RAM, same timing
  always @(posedge aclk) begin
    if (data_ram.en) begin
      if (data_ram.we) begin
        data_mem[data_ram.addr] <= data_ram.di;
      end
      data_do <= data_mem[data_ram.addr];
    end
  end

  // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic fir_cfg_pkg::data_t lfsr_word();
    fir_cfg_pkg::data_t w;
    for (int i = 0; i < 32; i++) begin
      w[i] = lfsr_bit();
    end
    return w;
  endfunction

  // y[n] = sum of tap[k] * x[n-k], earlier samples are zero, low 32 bits kept
  function automatic fir_cfg_pkg::data_t fir_ref(input int n, input int ntaps);
    fir_cfg_pkg::data_t acc;
    acc = '0;
    for (int k = 0; k < ntaps; k++) begin
      if (n - k >= 0) begin
        acc = acc + taps[k] * xs[n - k];
      end
    end
    return acc;
  endfunction

  task automatic stop_with_failure();
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_data(input fir_cfg_pkg::data_t got, input fir_cfg_pkg::data_t exp,
                            input string name);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got %b expected %b", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  // Address and data offered together, held until the slave takes them
  task automatic lite_write(input fir_cfg_pkg::lite_addr_t addr, input fir_cfg_pkg::data_t data);
    @(posedge aclk);
    s_awaddr  <= addr;
    s_awvalid <= 1'b1;
    s_wdata   <= data;
    s_wvalid  <= 1'b1;
    @(negedge aclk);
    while (!s_awready) @(negedge aclk);
    check_bit(s_wready, 1'b1, "s_wready");
    @(posedge aclk);
    s_awvalid <= 1'b0;
    s_wvalid  <= 1'b0;
  endtask

  task automatic lite_read(input fir_cfg_pkg::lite_addr_t addr,
                           output fir_cfg_pkg::data_t data);
    @(posedge aclk);
    s_araddr  <= addr;
    s_arvalid <= 1'b1;
    @(negedge aclk);
    while (!s_arready) @(negedge aclk);
    @(posedge aclk);
    s_arvalid <= 1'b0;
    // Registers answer after one cycle, taps after two
    @(negedge aclk);
    while (!s_rvalid) @(negedge aclk);
    // Response kept waiting one cycle before rready
    @(posedge aclk);
    s_rready <= 1'b1;
    @(negedge aclk);
    check_bit(s_rvalid, 1'b1, "s_rvalid");
    data = s_rdata;
    @(posedge aclk);
    s_rready <= 1'b0;
  endtask

  function automatic fir_cfg_pkg::lite_addr_t tap_addr(input int k);
    return fir_cfg_pkg::lite_addr_t'(fir_cfg_pkg::REG_TAP_BASE + 4 * k);
  endfunction

  task automatic check_reset_state();
    fir_cfg_pkg::data_t rd;
    @(negedge aclk);
    check_bit(ss_tready, 1'b1, "ss_tready");
    check_bit(sm_tvalid, 1'b0, "sm_tvalid");
    lite_read(fir_cfg_pkg::REG_AP_CTRL, rd);
    check_bit(rd[fir_cfg_pkg::AP_IDLE], 1'b1, "ap_idle");
    check_bit(rd[fir_cfg_pkg::AP_DONE], 1'b0, "ap_done");
    check_bit(rd[fir_cfg_pkg::AP_START], 1'b0, "ap_start");
    // Length and tap count read back
    lite_write(fir_cfg_pkg::REG_DATA_LEN, 32'd37);
    lite_write(fir_cfg_pkg::REG_TAP_NUM, 32'd11);
    lite_read(fir_cfg_pkg::REG_DATA_LEN, rd);
    check_data(rd, 32'd37, "data_len");
    lite_read(fir_cfg_pkg::REG_TAP_NUM, rd);
    check_data(rd, 32'd11, "tap_num");
  endtask

  // New random taps, written, then checked in the RAM and over the bus
  task automatic load_taps(input int ntaps);
    fir_cfg_pkg::data_t rd;
    for (int k = 0; k < ntaps; k++) begin
      taps[k] = lfsr_word();
      lite_write(tap_addr(k), taps[k]);
    end
    lite_write(fir_cfg_pkg::REG_TAP_NUM, fir_cfg_pkg::data_t'(ntaps));
    for (int k = 0; k < ntaps; k++) begin
      check_data(tap_mem[k], taps[k], "tap_mem");
      lite_read(tap_addr(k), rd);
      check_data(rd, taps[k], "tap readback");
    end
  endtask

  task automatic make_samples(input int count);
    for (int i = 0; i < count; i++) begin
      xs[i] = lfsr_word();
    end
  endtask

  task automatic send_samples(input int count);
    @(posedge aclk);
    for (int i = 0; i < count; i++) begin
      ss_tvalid <= 1'b1;
      ss_tdata  <= xs[i];
      @(negedge aclk);
      while (!ss_tready) @(negedge aclk);
      @(posedge aclk);
    end
    ss_tvalid <= 1'b0;
  endtask

  // Accepts outputs, optional random stalls, checks value, tlast and hold
  task automatic collect_outputs(input int count, input int ntaps, input bit random_ready);
    int                 got;
    bit                 stalled;
    logic               rdy;
    fir_cfg_pkg::data_t held;
    got     = 0;
    stalled = 1'b0;
    held    = '0;
    while (got < count) begin
      @(posedge aclk);
      rdy = random_ready ? lfsr_bit() : 1'b1;
      sm_tready <= rdy;
      @(negedge aclk);
      if (sm_tvalid) begin
        if (stalled) begin
          check_data(sm_tdata, held, "sm_tdata while stalled");
        end
        if (sm_tready) begin
          check_data(sm_tdata, fir_ref(got, ntaps), "sm_tdata");
          check_bit(sm_tlast, got == count - 1, "sm_tlast");
          got++;
          stalled = 1'b0;
        end else begin
          held    = sm_tdata;
          stalled = 1'b1;
        end
      end
    end
    run_over = 1'b1;
    @(posedge aclk);
    sm_tready <= 1'b0;
  endtask

  // Tap read once busy, must wait for the run to end
  task automatic probe_tap_read(input int k);
    fir_cfg_pkg::data_t rd;
    @(negedge aclk);
    while (!sm_tvalid) @(negedge aclk);
    lite_read(tap_addr(k), rd);
    check_bit(run_over, 1'b1, "run over at tap read return");
    check_data(rd, taps[k], "tap read during run");
  endtask

  task automatic wait_done();
    fir_cfg_pkg::data_t ctrl;
    ctrl = '0;
    while (!ctrl[fir_cfg_pkg::AP_DONE]) begin
      lite_read(fir_cfg_pkg::REG_AP_CTRL, ctrl);
    end
    check_bit(ctrl[fir_cfg_pkg::AP_IDLE], 1'b1, "ap_idle after run");
    check_bit(ctrl[fir_cfg_pkg::AP_START], 1'b0, "ap_start after run");
  endtask

  task automatic run_filter(input int count, input int ntaps, input bit random_ready,
                            input bit probe);
    lite_write(fir_cfg_pkg::REG_DATA_LEN, fir_cfg_pkg::data_t'(count));
    lite_write(fir_cfg_pkg::REG_AP_CTRL, 32'd1 << fir_cfg_pkg::AP_START);
    run_over = 1'b0;
    fork
      send_samples(count);
      collect_outputs(count, ntaps, random_ready);
      if (probe) probe_tap_read(ntaps / 2);
    join
    wait_done();
  endtask

  initial begin
    rst_n      = 1'b0;
    aclk       = 1'b0;
    s_awaddr   = '0;
    s_awvalid  = 1'b0;
    s_wdata    = '0;
    s_wvalid   = 1'b0;
    s_araddr   = '0;
    s_arvalid  = 1'b0;
    s_rready   = 1'b0;
    ss_tvalid  = 1'b0;
    ss_tdata   = '0;
    ss_tlast   = 1'b0;
    sm_tready  = 1'b0;
    run_over   = 1'b0;
    lfsr_state = 32'h223d;
    // Nonzero garbage so a missing clear shows up
    for (int i = 0; i < 1024; i++) begin
      tap_mem[i]  = 32'h7a00_0000 ^ (i * 32'h0001_0001);
      data_mem[i] = 32'h5c00_0000 ^ (i * 32'h0003_0007);
    end
    repeat (4) @(posedge aclk);
    rst_n <= 1'b1;
    check_reset_state();
    load_taps(8);
    make_samples(16);
    run_filter(16, 8, 1'b0, 1'b0);
    // Same data again under back-pressure, tap read parked on the busy core
    run_filter(16, 8, 1'b1, 1'b1);
    load_taps(5);
    make_samples(16);
    run_filter(16, 5, 1'b1, 1'b0);
    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: compile.f
fir_cfg_pkg.sv
fir_bus_pkg.sv
axi4_lite_slave.sv
axi4_stream_slave_bram.sv
bram_access_arbiter.sv
fir_core.sv
fir_top.sv
fir_top_properties.sv
tb_fir_top.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_fir_top -f compile.f -o tb_fir_top
out=$(./obj_dir/tb_fir_top 2>&1) || true
echo "$out"
if grep -qx "Finished with no errors" <<< "$out"; then
  exit 0
else
  exit 1
fi
